// File: build.f
+incdir+src
+incdir+tb
src/scoreboard_pkg.sv
src/toggle_set_if.sv
src/lfsr.sv
src/toggle_memory.sv
src/toggle_memory_set.sv
src/init_clear_fsm.sv
src/issue_gate.sv
src/reg_scoreboard.sv
tb/tb_reg_scoreboard.sv

// File: tb/scoreboard_ref.svh
// Reference scoreboard model: in-use flags, expected accept function, value compare task
`ifndef SCOREBOARD_REF_SVH
`define SCOREBOARD_REF_SVH

`include "scoreboard_consts.svh"

//////////////////////////////////////////////////
// Reference model

// One flag per register, set from issue until writeback
logic [`SB_NUM_REGS-1:0] model_busy;

// Accept when valid and no operand is outstanding
function automatic logic expected_accept(
    input logic                       valid,
    input scoreboard_pkg::phys_addr_t rs1,
    input scoreboard_pkg::phys_addr_t rs2,
    input scoreboard_pkg::phys_addr_t rd
);
    logic hazard;
    // Register 0 is always free
    hazard = (rs1 != 0 && model_busy[rs1]) || (rs2 != 0 && model_busy[rs2])
        || (rd != 0 && model_busy[rd]);
    return valid && !hazard;
endfunction

//////////////////////////////////////////////////
// Compare

// X on the DUT side counts as a mismatch
task automatic check_value(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] exp
);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_on_failure();
    end
endtask

`endif

// File: tb/tb_reg_scoreboard.sv
// Scoreboard testbench: clock, reset, directed and random stimulus, model compare process
`timescale 1ns/1ns
`default_nettype none

`include "scoreboard_consts.svh"

module tb_reg_scoreboard;

    localparam int READY_TIMEOUT = 4 * `SB_NUM_REGS;

    logic                       clk;
    logic                       rst;
    logic                       issue_valid;
    scoreboard_pkg::phys_addr_t issue_rs1;
    scoreboard_pkg::phys_addr_t issue_rs2;
    scoreboard_pkg::phys_addr_t issue_rd;
    logic                       issue_accept;
    logic                       wb_valid [`SB_NUM_WB];
    scoreboard_pkg::phys_addr_t wb_addr  [`SB_NUM_WB];
    logic                       ready;
    int                         seed;
    logic                       exp_accept;
    logic                       exp_ready;
    // Edges since reset release, saturates once ready is due
    int                         since_reset;

    `include "scoreboard_ref.svh"

    reg_scoreboard u_reg_scoreboard (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rd     (issue_rd),
        .issue_accept (issue_accept),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .ready        (ready)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "Stopping at first error");
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers

    // New request on the falling edge, writebacks idle
    task automatic drive_issue(
        input logic                       valid,
        input scoreboard_pkg::phys_addr_t rs1,
        input scoreboard_pkg::phys_addr_t rs2,
        input scoreboard_pkg::phys_addr_t rd
    );
        @(negedge clk);
        issue_valid = valid;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_rd    = rd;
        for (int w = 0; w < `SB_NUM_WB; w++) begin
            wb_valid[w] = 1'b0;
        end
    endtask

    // Adds a writeback to the cycle just driven
    task automatic drive_writeback(input int port, input scoreboard_pkg::phys_addr_t addr);
        wb_valid[port] = 1'b1;
        wb_addr[port]  = addr;
    endtask

    // Holds reset 4 cycles, then counts cycles until ready
    task automatic apply_reset();
        int cycles;
        drive_issue(1'b0, 0, 0, 0);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        check_value("ready", ready, 0);
        rst    = 1'b0;
        cycles = 0;
        // Requests and writebacks during the sweep must not reach the banks
        issue_valid = 1'b1;
        wb_valid[0] = 1'b1;
        wb_addr[0]  = '0;
        while (!ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            wb_addr[0] = scoreboard_pkg::phys_addr_t'(cycles);
        end
        issue_valid = 1'b0;
        wb_valid[0] = 1'b0;
        if (!ready) begin
            $display("Timed out waiting for ready after reset");
            stop_on_failure();
        end
        check_value("ready_latency", cycles, `SB_NUM_REGS + 1);
    endtask

    // Every register must read free as a source
    task automatic check_all_free();
        for (int r = 0; r < `SB_NUM_REGS; r++) begin
            drive_issue(1'b1, scoreboard_pkg::phys_addr_t'(r),
                scoreboard_pkg::phys_addr_t'(`SB_NUM_REGS - 1 - r), 0);
        end
    endtask

    // Writebacks only target busy registers, distinct per cycle
    task automatic drive_random();
        scoreboard_pkg::phys_addr_t a;
        drive_issue(1'($random(seed)), scoreboard_pkg::phys_addr_t'($random(seed)),
            scoreboard_pkg::phys_addr_t'($random(seed)),
            scoreboard_pkg::phys_addr_t'($random(seed)));
        for (int w = 0; w < `SB_NUM_WB; w++) begin
            a = scoreboard_pkg::phys_addr_t'($random(seed));
            if (model_busy[a] && !(w > 0 && wb_valid[0] && wb_addr[0] == a)) begin
                drive_writeback(w, a);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Compare process

    always @(posedge clk) begin
        if (rst) begin
            model_busy  = '0;
            since_reset = 0;
        end else begin
            // Ready is due SB_NUM_REGS + 1 edges after reset release
            exp_ready = (since_reset > `SB_NUM_REGS);
            check_value("ready", ready, exp_ready);
            if (exp_ready) begin
                exp_accept = expected_accept(issue_valid, issue_rs1, issue_rs2, issue_rd);
                check_value("issue_accept", issue_accept, exp_accept);
                if (exp_accept && issue_rd != 0) begin
                    model_busy[issue_rd] = 1'b1;
                end
                for (int w = 0; w < `SB_NUM_WB; w++) begin
                    if (wb_valid[w] && wb_addr[w] != 0) begin
                        model_busy[wb_addr[w]] = 1'b0;
                    end
                end
            end else begin
                check_value("issue_accept", issue_accept, 0);
                since_reset++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        seed        = 32'h6547_fbc5;
        since_reset = 0;
        model_busy  = '0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_rd    = '0;
        for (int w = 0; w < `SB_NUM_WB; w++) begin
            wb_valid[w] = 1'b0;
            wb_addr[w]  = '0;
        end

        apply_reset();
        check_all_free();

        // rd hazard blocks all three operand slots until freed
        drive_issue(1'b1, 0, 0, 5);
        drive_issue(1'b1, 5, 0, 0);
        drive_issue(1'b1, 0, 5, 0);
        drive_issue(1'b1, 0, 0, 5);
        drive_issue(1'b0, 0, 0, 0);
        drive_writeback(1, 5);
        drive_issue(1'b1, 5, 5, 5);
        drive_issue(1'b0, 0, 0, 0);
        drive_writeback(0, 5);

        // Two writebacks and an issue in one cycle
        drive_issue(1'b1, 0, 0, 7);
        drive_issue(1'b1, 0, 0, 8);
        drive_issue(1'b1, 0, 0, 9);
        drive_writeback(0, 7);
        drive_writeback(1, 8);
        drive_issue(1'b1, 7, 8, 0);
        drive_issue(1'b1, 9, 0, 0);
        drive_issue(1'b0, 0, 0, 0);
        drive_writeback(0, 9);

        // Register 0 never tracked
        drive_issue(1'b1, 0, 0, 0);
        drive_issue(1'b1, 0, 0, 0);
        drive_writeback(0, 0);
        drive_issue(1'b1, 0, 0, 0);

        repeat (1000) drive_random();
        // Mid-run reset must free everything again
        apply_reset();
        check_all_free();
        repeat (1000) drive_random();

        drive_issue(1'b0, 0, 0, 0);
        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/reg_scoreboard.sv
// Scoreboard top level: sequencer, init state machine, issue gate and toggle memory set
`timescale 1ns/1ns
`default_nettype none

`include "scoreboard_consts.svh"

module reg_scoreboard (
    input  logic                       clk,
    input  logic                       rst,

    // Issue request, accept is same-cycle
    input  logic                       issue_valid,
    input  scoreboard_pkg::phys_addr_t issue_rs1,
    input  scoreboard_pkg::phys_addr_t issue_rs2,
    input  scoreboard_pkg::phys_addr_t issue_rd,
    output logic                       issue_accept,

    // Writebacks, never stalled
    input  logic                       wb_valid [`SB_NUM_WB],
    input  scoreboard_pkg::phys_addr_t wb_addr  [`SB_NUM_WB],

    output logic                       ready
);

    toggle_set_if tsi ();

    logic                       seq_en;
    logic                       seq_wrap;
    scoreboard_pkg::phys_addr_t seq_addr;
    scoreboard_pkg::wb_port_t   wb [`SB_NUM_WB];

    // Pack each writeback into its struct
    for (genvar w = 0; w < `SB_NUM_WB; w++) begin : g_wb_pack
        assign wb[w] = '{valid: wb_valid[w], addr: wb_addr[w]};
    end

    //////////////////////////////////////////////////
    // Post-reset clear

    lfsr u_lfsr (
        .clk   (clk),
        .rst   (rst),
        .en    (seq_en),
        .value (seq_addr),
        .wrap  (seq_wrap)
    );

    init_clear_fsm u_init_clear_fsm (
        .clk      (clk),
        .rst      (rst),
        .wrap     (seq_wrap),
        .seq_en   (seq_en),
        .ready    (ready),
        .tsi      (tsi.ctrl),
        .seq_addr (seq_addr)
    );

    //////////////////////////////////////////////////
    // Issue path and status storage

    issue_gate u_issue_gate (
        .ready        (ready),
        .issue_valid  (issue_valid),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rd     (issue_rd),
        .wb           (wb),
        .issue_accept (issue_accept),
        .tsi          (tsi.gate)
    );

    // One bank for issue plus one per writeback
    toggle_memory_set #(
        .NUM_WRITE_PORTS (1 + `SB_NUM_WB),
        .NUM_READ_PORTS  (`SB_NUM_READS)
    ) u_toggle_memory_set (
        .clk (clk),
        .tsi (tsi.mem)
    );

endmodule

`default_nettype wire

// File: src/issue_gate.sv
// Issue gate: operand hazard check, accept, and toggle drive for issue and writebacks
`timescale 1ns/1ns
`default_nettype none

`include "scoreboard_consts.svh"

module issue_gate (
    input  logic                       ready,
    input  logic                       issue_valid,
    input  scoreboard_pkg::phys_addr_t issue_rs1,
    input  scoreboard_pkg::phys_addr_t issue_rs2,
    input  scoreboard_pkg::phys_addr_t issue_rd,
    input  scoreboard_pkg::wb_port_t   wb [`SB_NUM_WB],
    output logic                       issue_accept,
    toggle_set_if.gate                 tsi
);

    // Read port slots
    localparam int RD_RS1 = 0;
    localparam int RD_RS2 = 1;
    localparam int RD_RD  = 2;

    logic [`SB_NUM_READS-1:0] operand_busy;

    //////////////////////////////////////////////////
    // Status reads

    always_comb begin
        tsi.read_addr[RD_RS1] = issue_rs1;
        tsi.read_addr[RD_RS2] = issue_rs2;
        tsi.read_addr[RD_RD]  = issue_rd;
    end

    // Register 0 is never tracked, treat it as free
    always_comb begin
        for (int i = 0; i < `SB_NUM_READS; i++) begin
            operand_busy[i] = tsi.in_use[i] && (tsi.read_addr[i] != '0);
        end
    end

    // Sources and destination must all be idle
    assign issue_accept = ready && issue_valid && (operand_busy == '0);

    //////////////////////////////////////////////////
    // Toggle drive

    always_comb begin
        // Port 0 marks the destination busy
        tsi.toggle[0]      = issue_accept && (issue_rd != '0);
        tsi.toggle_addr[0] = issue_rd;
        // Writebacks free their register, blocked until the sweep is done
        for (int w = 0; w < `SB_NUM_WB; w++) begin
            tsi.toggle[w+1]      = ready && wb[w].valid && (wb[w].addr != '0);
            tsi.toggle_addr[w+1] = wb[w].addr;
        end
    end

endmodule

`default_nettype wire

// File: src/init_clear_fsm.sv
// Init state machine: post-reset clear sweep over all registers, then ready
`timescale 1ns/1ns
`default_nettype none

module init_clear_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wrap,
    output logic                       seq_en,
    output logic                       ready,
    toggle_set_if.ctrl                 tsi,
    input  scoreboard_pkg::phys_addr_t seq_addr
);

    scoreboard_pkg::sb_state_t state;
    scoreboard_pkg::sb_state_t state_next;

    //////////////////////////////////////////////////
    // Next state

    always_comb begin
        state_next = state;
        case (state)
            // One idle cycle, sequencer sits at the seed
            scoreboard_pkg::SB_START: state_next = scoreboard_pkg::SB_CLEAR;
            // Leave once the last address has been cleared
            scoreboard_pkg::SB_CLEAR: begin
                if (wrap) begin
                    state_next = scoreboard_pkg::SB_READY;
                end
            end
            scoreboard_pkg::SB_READY: state_next = scoreboard_pkg::SB_READY;
            default: state_next = scoreboard_pkg::SB_START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= scoreboard_pkg::SB_START;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////////////////////////
    // Outputs

    // Sequencer steps and banks clear only during the sweep
    assign seq_en         = (state == scoreboard_pkg::SB_CLEAR);
    assign tsi.clear      = seq_en;
    assign tsi.clear_addr = seq_addr;
    assign ready          = (state == scoreboard_pkg::SB_READY);

endmodule

`default_nettype wire

// File: src/toggle_memory_set.sv
// Toggle memory set: one bank per write port, XOR of bank reads gives in-use status
`timescale 1ns/1ns
`default_nettype none

module toggle_memory_set #(
    parameter int NUM_WRITE_PORTS = 3,
    parameter int NUM_READ_PORTS  = 3
) (
    input logic         clk,
    toggle_set_if.mem   tsi
);

    // Bank j, read port i
    logic read_data [NUM_WRITE_PORTS][NUM_READ_PORTS];
    // Combined status per read port
    logic status    [NUM_READ_PORTS];

    //////////////////////////////////////////////////
    // Banks

    // Each write port flips bits only in its own bank,
    // so all ports can update in one cycle without conflict
    for (genvar j = 0; j < NUM_WRITE_PORTS; j++) begin : g_bank
        toggle_memory #(
            .NUM_READ_PORTS (NUM_READ_PORTS)
        ) u_bank (
            .clk         (clk),
            .toggle      (tsi.toggle[j]),
            .toggle_addr (tsi.toggle_addr[j]),
            // Sweep zeroes the same address in every bank
            .clear       (tsi.clear),
            .clear_addr  (tsi.clear_addr),
            .read_addr   (tsi.read_addr),
            .read_data   (read_data[j])
        );
    end

    //////////////////////////////////////////////////
    // Status combine

    // Register is in use when an odd number of banks hold a one
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            status[i] = 1'b0;
            for (int j = 0; j < NUM_WRITE_PORTS; j++) begin
                status[i] = status[i] ^ read_data[j][i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            tsi.in_use[i] = status[i];
        end
    end

endmodule

`default_nettype wire

// File: src/toggle_memory.sv
// Single toggle bank: one bit per register, toggle port, clear port, combinational reads
`timescale 1ns/1ns
`default_nettype none

`include "scoreboard_consts.svh"

module toggle_memory #(
    parameter int NUM_READ_PORTS = 3
) (
    input  logic                       clk,

    input  logic                       toggle,
    input  scoreboard_pkg::phys_addr_t toggle_addr,

    input  logic                       clear,
    input  scoreboard_pkg::phys_addr_t clear_addr,

    input  scoreboard_pkg::phys_addr_t read_addr [NUM_READ_PORTS],
    output logic                       read_data [NUM_READ_PORTS]
);

    //////////////////////////////////////////////////
    // Storage

    // Contents are undefined until the clear sweep finishes
    logic [`SB_NUM_REGS-1:0] bits;

    always_ff @(posedge clk) begin
        if (toggle) begin
            bits[toggle_addr] <= ~bits[toggle_addr];
        end
        // Clear comes last so it wins on an address collision
        if (clear) begin
            bits[clear_addr] <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Read ports

    // Asynchronous reads, new value visible right after the edge
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            read_data[i] = bits[read_addr[i]];
        end
    end

endmodule

`default_nettype wire

// File: src/lfsr.sv
// Fibonacci LFSR extended through the all-zero state, with a wrap flag at the seed
`timescale 1ns/1ns
`default_nettype none

`include "scoreboard_consts.svh"

module lfsr (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       en,
    output scoreboard_pkg::phys_addr_t value,
    output logic                       wrap
);

    localparam int WIDTH = $bits(scoreboard_pkg::phys_addr_t);
    localparam scoreboard_pkg::phys_addr_t SEED = `SB_LFSR_SEED;

    // Feedback taps for maximal-length sequences, MSB always tapped
    function automatic logic [7:0] tap_mask(input int width);
        case (width)
            3:       return 8'b0000_0110;
            4:       return 8'b0000_1100;
            5:       return 8'b0001_0100;
            7:       return 8'b0110_0000;
            8:       return 8'b1011_1000;
            default: return 8'b0011_0000;
        endcase
    endfunction

    localparam logic [WIDTH-1:0] TAPS = WIDTH'(tap_mask(WIDTH));

    scoreboard_pkg::phys_addr_t next_value;
    logic                       feedback;

    always_comb begin
        feedback = ^(value & TAPS);
        // Extra term inserts the all-zero state after 100..0
        if (value[WIDTH-2:0] == '0) begin
            feedback = ~feedback;
        end
        next_value = {value[WIDTH-2:0], feedback};
    end

    // High on the last address before the sequence repeats
    assign wrap = (next_value == SEED);

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= SEED;
        end else if (en) begin
            value <= next_value;
        end
    end

endmodule

`default_nettype wire

// File: src/toggle_set_if.sv
// Toggle memory set interface: toggle, read and clear signals with gate, ctrl and mem modports
`timescale 1ns/1ns
`default_nettype none

`include "scoreboard_consts.svh"

interface toggle_set_if;

    // Entry 0 is the issue port, the rest are writebacks
    logic                       toggle      [1 + `SB_NUM_WB];
    scoreboard_pkg::phys_addr_t toggle_addr [1 + `SB_NUM_WB];

    // Read order is rs1, rs2, rd
    scoreboard_pkg::phys_addr_t read_addr [`SB_NUM_READS];
    logic                       in_use    [`SB_NUM_READS];

    // Post-reset sweep, writes zero into every bank
    logic                       clear;
    scoreboard_pkg::phys_addr_t clear_addr;

    // Issue gate side
    modport gate (output toggle, toggle_addr, read_addr, input in_use);
    // Init state machine side
    modport ctrl (output clear, clear_addr);
    // Storage side
    modport mem (input toggle, toggle_addr, read_addr, clear, clear_addr, output in_use);

endinterface

`default_nettype wire

// File: src/scoreboard_pkg.sv
// Scoreboard types: register address, init state encoding, writeback port struct
`default_nettype none

`include "scoreboard_consts.svh"

package scoreboard_pkg;

    //////////////////////////////////////////////////
    // Register address

    // Wide enough to index every physical register
    typedef logic [$clog2(`SB_NUM_REGS)-1:0] phys_addr_t;

    //////////////////////////////////////////////////
    // Init sequence states

    typedef enum logic [1:0] {
        SB_START = 2'd0,
        SB_CLEAR = 2'd1,
        SB_READY = 2'd2
    } sb_state_t;

    // One writeback port, valid in the MSB
    typedef struct packed {
        logic       valid;
        phys_addr_t addr;
    } wb_port_t;

endpackage

`default_nettype wire

// File: src/scoreboard_consts.svh
// Scoreboard sizing macros: register count, writeback ports, read ports, sequencer seed
`ifndef SCOREBOARD_CONSTS_SVH
`define SCOREBOARD_CONSTS_SVH

//////////////////////////////////////////////////
// Register file size

// Physical registers tracked, register 0 included
`define SB_NUM_REGS 64

//////////////////////////////////////////////////
// Port counts

// Writeback ports, each one owns a bank
`define SB_NUM_WB 2

// Status reads per issue request (rs1, rs2, rd)
`define SB_NUM_READS 3

// First address of the clear sweep
`define SB_LFSR_SEED 1

`endif
